/* source/core_isa_pkg.sv */
////////////////////////////////////////
// instruction-set types for the core
// opcode and ALU operation enums
// instruction field codes, reset PC and NOP
////////////////////////////////////////
`default_nettype none

package core_isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR
	} alu_op_e;

	// funct3 and funct7 codes for the supported subset
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;
	localparam logic [2:0] F3_WORD    = 3'b010;
	localparam logic [2:0] F3_BEQ     = 3'b000;
	localparam logic [2:0] F3_BNE     = 3'b001;
	localparam logic [6:0] F7_SUB     = 7'b0100000;

	localparam word_t RESET_PC  = 32'h0000_0000;
	// addi x0, x0, 0
	localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire

/* source/core_pipe_pkg.sv */
////////////////////////////////////////
// pipeline-side types for the core
// memory operation, branch kind, hold code
////////////////////////////////////////
`default_nettype none

package core_pipe_pkg;

	typedef enum logic [1:0] {
		MEM_OP_NONE,
		MEM_OP_LOAD,
		MEM_OP_STORE
	} mem_op_e;

	typedef enum logic [1:0] {
		JMP_NONE,
		JMP_BEQ,
		JMP_BNE,
		JMP_JAL
	} jmp_flag_e;

	typedef enum logic {
		RUN  = 1'b0,
		HOLD = 1'b1
	} hold_code_e;

	// values of mem_state_o
	localparam logic MEM_RD = 1'b0;
	localparam logic MEM_WR = 1'b1;

endpackage

`default_nettype wire

/* source/core_bus_if.sv */
////////////////////////////////////////
// id_ex_if: decoded bundle into execute
// reg_rd_if: register file read ports
////////////////////////////////////////
`default_nettype none

interface id_ex_if;
	core_isa_pkg::alu_op_e   alu_op;
	core_isa_pkg::word_t     op_num1;
	core_isa_pkg::word_t     op_num2;
	core_isa_pkg::word_t     store_data;
	core_pipe_pkg::mem_op_e  mem_op;
	core_isa_pkg::reg_addr_t rd;
	logic                    rd_wr_en;

	modport id (output alu_op, op_num1, op_num2, store_data, mem_op, rd, rd_wr_en);
	modport ex (input alu_op, op_num1, op_num2, store_data, mem_op, rd, rd_wr_en);
endinterface

interface reg_rd_if;
	core_isa_pkg::reg_addr_t addr_rs1;
	core_isa_pkg::reg_addr_t addr_rs2;
	core_isa_pkg::word_t     data_rs1;
	core_isa_pkg::word_t     data_rs2;

	modport id   (output addr_rs1, addr_rs2, input data_rs1, data_rs2);
	modport read (input addr_rs1, addr_rs2, output data_rs1, data_rs2);
endinterface

`default_nettype wire

/* source/fetch_stage.sv */
////////////////////////////////////////
// program counter and fetch stage
// jump redirect, read enable, fetch mask
////////////////////////////////////////
`default_nettype none

module fetch_stage (
	input  logic                      clk,
	input  logic                      rst_i,
	input  core_pipe_pkg::hold_code_e hold_code_i,
	input  logic                      jmp_en_i,
	input  core_isa_pkg::word_t       jmp_to_i,
	input  core_isa_pkg::word_t       instr_i,
	input  logic                      instr_mask_i,
	output core_isa_pkg::word_t       pc_o,
	output logic                      instr_rd_en_o,
	output core_isa_pkg::word_t       instr_o
);

	core_isa_pkg::word_t pc_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc_q <= core_isa_pkg::RESET_PC;
		end else if (hold_code_i == core_pipe_pkg::RUN) begin
			pc_q <= jmp_en_i ? jmp_to_i : pc_q + 32'd4;
		end
	end

	assign pc_o          = pc_q;
	assign instr_rd_en_o = (hold_code_i == core_pipe_pkg::RUN);

	// the word fetched behind a taken transfer becomes a bubble
	assign instr_o = instr_mask_i ? core_isa_pkg::NOP_INSTR : instr_i;

endmodule

`default_nettype wire

/* source/id_stage.sv */
////////////////////////////////////////
// decode stage: instruction register,
// field and immediate decode, operand
// bypass, execute bundle, branch operands
////////////////////////////////////////
`default_nettype none

module id_stage (
	input  logic                        clk,
	input  logic                        rst_i,
	input  core_pipe_pkg::hold_code_e   hold_code_i,
	input  core_isa_pkg::word_t         instr_i,
	input  core_isa_pkg::word_t         addr_instr_i,
	input  core_isa_pkg::word_t         bypass_data_i,
	input  core_isa_pkg::reg_addr_t     bypass_rd_i,
	input  logic                        bypass_en_i,
	reg_rd_if.id                        rd_port,
	id_ex_if.id                         ex_port,
	output core_pipe_pkg::jmp_flag_e    jmp_flag_o,
	output core_isa_pkg::word_t         jmpb_rs1_o,
	output core_isa_pkg::word_t         jmpb_rs2_o,
	output core_isa_pkg::word_t         imm_o,
	output core_isa_pkg::word_t         pc_id_o
);

	core_isa_pkg::word_t     instr_q;
	core_isa_pkg::word_t     pc_q;
	core_isa_pkg::opcode_e   opcode;
	core_isa_pkg::reg_addr_t rs1;
	core_isa_pkg::reg_addr_t rs2;
	logic [2:0]              funct3;
	logic [6:0]              funct7;
	core_isa_pkg::word_t     imm_i, imm_s, imm_b, imm_j;
	core_isa_pkg::word_t     rs1_val, rs2_val;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			instr_q <= core_isa_pkg::NOP_INSTR;
		end else if (hold_code_i == core_pipe_pkg::RUN) begin
			instr_q <= instr_i;
		end
	end

	always_ff @(posedge clk) begin
		if (hold_code_i == core_pipe_pkg::RUN) begin
			pc_q <= addr_instr_i;
		end
	end

	assign opcode = core_isa_pkg::opcode_e'(instr_q[6:0]);
	assign rs1    = instr_q[19:15];
	assign rs2    = instr_q[24:20];
	assign funct3 = instr_q[14:12];
	assign funct7 = instr_q[31:25];

	assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
	assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
	assign imm_b = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
		instr_q[11:8], 1'b0};
	assign imm_j = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
		instr_q[30:21], 1'b0};

	assign rd_port.addr_rs1 = rs1;
	assign rd_port.addr_rs2 = rs2;

	// the result still in execute wins over the register file
	assign rs1_val = (bypass_en_i && bypass_rd_i == rs1 && rs1 != 5'd0) ?
		bypass_data_i : rd_port.data_rs1;
	assign rs2_val = (bypass_en_i && bypass_rd_i == rs2 && rs2 != 5'd0) ?
		bypass_data_i : rd_port.data_rs2;

	assign jmpb_rs1_o = rs1_val;
	assign jmpb_rs2_o = rs2_val;
	assign pc_id_o    = pc_q;

	always_comb begin
		ex_port.alu_op     = core_isa_pkg::ALU_ADD;
		ex_port.op_num1    = rs1_val;
		ex_port.op_num2    = rs2_val;
		ex_port.store_data = rs2_val;
		ex_port.mem_op     = core_pipe_pkg::MEM_OP_NONE;
		ex_port.rd         = instr_q[11:7];
		ex_port.rd_wr_en   = 1'b0;
		jmp_flag_o         = core_pipe_pkg::JMP_NONE;
		imm_o              = imm_i;
		case (opcode)
			core_isa_pkg::OPC_OP: begin
				ex_port.rd_wr_en = 1'b1;
				case (funct3)
					core_isa_pkg::F3_ADD_SUB: ex_port.alu_op = (funct7 == core_isa_pkg::F7_SUB) ?
						core_isa_pkg::ALU_SUB : core_isa_pkg::ALU_ADD;
					core_isa_pkg::F3_XOR: ex_port.alu_op = core_isa_pkg::ALU_XOR;
					core_isa_pkg::F3_OR:  ex_port.alu_op = core_isa_pkg::ALU_OR;
					core_isa_pkg::F3_AND: ex_port.alu_op = core_isa_pkg::ALU_AND;
					default: ex_port.rd_wr_en = 1'b0;
				endcase
			end
			core_isa_pkg::OPC_OP_IMM: begin
				ex_port.op_num2  = imm_i;
				ex_port.rd_wr_en = (funct3 == core_isa_pkg::F3_ADD_SUB);
			end
			core_isa_pkg::OPC_LOAD: begin
				ex_port.op_num2 = imm_i;
				if (funct3 == core_isa_pkg::F3_WORD) begin
					ex_port.mem_op   = core_pipe_pkg::MEM_OP_LOAD;
					ex_port.rd_wr_en = 1'b1;
				end
			end
			core_isa_pkg::OPC_STORE: begin
				ex_port.op_num2 = imm_s;
				imm_o           = imm_s;
				if (funct3 == core_isa_pkg::F3_WORD) begin
					ex_port.mem_op = core_pipe_pkg::MEM_OP_STORE;
				end
			end
			core_isa_pkg::OPC_BRANCH: begin
				imm_o = imm_b;
				if (funct3 == core_isa_pkg::F3_BEQ) begin
					jmp_flag_o = core_pipe_pkg::JMP_BEQ;
				end else if (funct3 == core_isa_pkg::F3_BNE) begin
					jmp_flag_o = core_pipe_pkg::JMP_BNE;
				end
			end
			core_isa_pkg::OPC_JAL: begin
				// link value pc + 4 goes through the ALU
				imm_o            = imm_j;
				jmp_flag_o       = core_pipe_pkg::JMP_JAL;
				ex_port.op_num1  = pc_q;
				ex_port.op_num2  = 32'd4;
				ex_port.rd_wr_en = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* source/ex_stage.sv */
////////////////////////////////////////
// execute stage: bundle register, ALU,
// data memory port and write-back value
////////////////////////////////////////
`default_nettype none

module ex_stage (
	input  logic                      clk,
	input  logic                      rst_i,
	input  core_pipe_pkg::hold_code_e hold_code_i,
	id_ex_if.ex                       ex_port,
	input  core_isa_pkg::word_t       data_mem_i,
	output core_isa_pkg::word_t       addr_mem_o,
	output core_isa_pkg::word_t       data_mem_wr_o,
	output logic                      mem_state_o,
	output logic                      reg_wr_en_o,
	output core_isa_pkg::reg_addr_t   reg_addr_wr_o,
	output core_isa_pkg::word_t       reg_data_wr_o
);

	core_isa_pkg::alu_op_e   alu_op_q;
	core_isa_pkg::word_t     op_num1_q, op_num2_q;
	core_isa_pkg::word_t     store_data_q;
	core_pipe_pkg::mem_op_e  mem_op_q;
	core_isa_pkg::reg_addr_t rd_q;
	logic                    rd_wr_en_q;
	core_isa_pkg::word_t     alu_result;
	logic                    run;

	assign run = (hold_code_i == core_pipe_pkg::RUN);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			mem_op_q   <= core_pipe_pkg::MEM_OP_NONE;
			rd_wr_en_q <= 1'b0;
		end else if (run) begin
			mem_op_q   <= ex_port.mem_op;
			rd_wr_en_q <= ex_port.rd_wr_en;
		end
	end

	always_ff @(posedge clk) begin
		if (run) begin
			alu_op_q     <= ex_port.alu_op;
			op_num1_q    <= ex_port.op_num1;
			op_num2_q    <= ex_port.op_num2;
			store_data_q <= ex_port.store_data;
			rd_q         <= ex_port.rd;
		end
	end

	always_comb begin
		case (alu_op_q)
			core_isa_pkg::ALU_ADD: alu_result = op_num1_q + op_num2_q;
			core_isa_pkg::ALU_SUB: alu_result = op_num1_q - op_num2_q;
			core_isa_pkg::ALU_AND: alu_result = op_num1_q & op_num2_q;
			core_isa_pkg::ALU_OR:  alu_result = op_num1_q | op_num2_q;
			core_isa_pkg::ALU_XOR: alu_result = op_num1_q ^ op_num2_q;
			default:               alu_result = '0;
		endcase
	end

	// loads and stores address memory with the ALU sum
	assign addr_mem_o    = alu_result;
	assign data_mem_wr_o = store_data_q;
	assign mem_state_o   = (run && mem_op_q == core_pipe_pkg::MEM_OP_STORE) ?
		core_pipe_pkg::MEM_WR : core_pipe_pkg::MEM_RD;

	assign reg_wr_en_o   = rd_wr_en_q && run;
	assign reg_addr_wr_o = rd_q;
	assign reg_data_wr_o = (mem_op_q == core_pipe_pkg::MEM_OP_LOAD) ? data_mem_i : alu_result;

endmodule

`default_nettype wire

/* source/regs.sv */
////////////////////////////////////////
// 32 x 32 register file, x0 reads zero,
// write-through on same-cycle read
////////////////////////////////////////
`default_nettype none

module regs (
	input  logic                    clk,
	input  logic                    rst_i,
	input  logic                    wr_en_i,
	input  core_isa_pkg::reg_addr_t addr_wr_i,
	input  core_isa_pkg::word_t     data_wr_i,
	reg_rd_if.read                  rd_port
);

	core_isa_pkg::word_t mem [32];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < 32; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_en_i && addr_wr_i != 5'd0) begin
			mem[addr_wr_i] <= data_wr_i;
		end
	end

	assign rd_port.data_rs1 = (wr_en_i && addr_wr_i != 5'd0 && addr_wr_i == rd_port.addr_rs1) ?
		data_wr_i : mem[rd_port.addr_rs1];
	assign rd_port.data_rs2 = (wr_en_i && addr_wr_i != 5'd0 && addr_wr_i == rd_port.addr_rs2) ?
		data_wr_i : mem[rd_port.addr_rs2];

endmodule

`default_nettype wire

/* source/ctrl.sv */
////////////////////////////////////////
// pipeline control: branch resolve,
// target, fetch mask and hold code
////////////////////////////////////////
`default_nettype none

module ctrl (
	input  logic                       stall_i,
	input  core_pipe_pkg::jmp_flag_e   jmp_flag_i,
	input  core_isa_pkg::word_t        jmpb_rs1_i,
	input  core_isa_pkg::word_t        jmpb_rs2_i,
	input  core_isa_pkg::word_t        imm_i,
	input  core_isa_pkg::word_t        pc_id_i,
	output logic                       jmp_en_o,
	output core_isa_pkg::word_t        jmp_to_o,
	output logic                       instr_mask_o,
	output core_pipe_pkg::hold_code_e  hold_code_o
);

	logic equal;
	logic taken;

	assign equal = (jmpb_rs1_i == jmpb_rs2_i);

	always_comb begin
		case (jmp_flag_i)
			core_pipe_pkg::JMP_BEQ: taken = equal;
			core_pipe_pkg::JMP_BNE: taken = !equal;
			core_pipe_pkg::JMP_JAL: taken = 1'b1;
			default:                taken = 1'b0;
		endcase
	end

	assign hold_code_o = stall_i ? core_pipe_pkg::HOLD : core_pipe_pkg::RUN;

	// a held branch resolves again once the stall drops
	assign jmp_en_o     = taken && !stall_i;
	assign jmp_to_o     = pc_id_i + imm_i;
	assign instr_mask_o = jmp_en_o;

endmodule

`default_nettype wire

/* source/core.sv */
////////////////////////////////////////
// core top level: fetch, decode, execute,
// register file and pipeline control
////////////////////////////////////////
`default_nettype none

module core (
	input  logic                clk,
	input  logic                rst_i,
	input  logic                stall_i,
	input  core_isa_pkg::word_t instr_i,
	input  core_isa_pkg::word_t addr_instr_i,
	input  core_isa_pkg::word_t data_mem_i,
	output logic                mem_state_o,
	output logic                instr_rd_en_o,
	output core_isa_pkg::word_t data_mem_wr_o,
	output core_isa_pkg::word_t addr_mem_o,
	output core_isa_pkg::word_t pc_o
);

	core_pipe_pkg::hold_code_e hold_code;
	core_pipe_pkg::jmp_flag_e  jmp_flag;
	logic                      jmp_en;
	logic                      instr_mask;
	core_isa_pkg::word_t       jmp_to;
	core_isa_pkg::word_t       fetch_instr;
	core_isa_pkg::word_t       jmpb_rs1, jmpb_rs2, imm, pc_id;
	logic                      wb_en;
	core_isa_pkg::reg_addr_t   wb_addr;
	core_isa_pkg::word_t       wb_data;

	id_ex_if  ex_bus ();
	reg_rd_if rd_bus ();

	fetch_stage u_fetch (
		.clk           (clk),
		.rst_i         (rst_i),
		.hold_code_i   (hold_code),
		.jmp_en_i      (jmp_en),
		.jmp_to_i      (jmp_to),
		.instr_i       (instr_i),
		.instr_mask_i  (instr_mask),
		.pc_o          (pc_o),
		.instr_rd_en_o (instr_rd_en_o),
		.instr_o       (fetch_instr)
	);

	id_stage u_id (
		.clk           (clk),
		.rst_i         (rst_i),
		.hold_code_i   (hold_code),
		.instr_i       (fetch_instr),
		.addr_instr_i  (addr_instr_i),
		.bypass_data_i (wb_data),
		.bypass_rd_i   (wb_addr),
		.bypass_en_i   (wb_en),
		.rd_port       (rd_bus.id),
		.ex_port       (ex_bus.id),
		.jmp_flag_o    (jmp_flag),
		.jmpb_rs1_o    (jmpb_rs1),
		.jmpb_rs2_o    (jmpb_rs2),
		.imm_o         (imm),
		.pc_id_o       (pc_id)
	);

	ex_stage u_ex (
		.clk           (clk),
		.rst_i         (rst_i),
		.hold_code_i   (hold_code),
		.ex_port       (ex_bus.ex),
		.data_mem_i    (data_mem_i),
		.addr_mem_o    (addr_mem_o),
		.data_mem_wr_o (data_mem_wr_o),
		.mem_state_o   (mem_state_o),
		.reg_wr_en_o   (wb_en),
		.reg_addr_wr_o (wb_addr),
		.reg_data_wr_o (wb_data)
	);

	regs u_regs (
		.clk       (clk),
		.rst_i     (rst_i),
		.wr_en_i   (wb_en),
		.addr_wr_i (wb_addr),
		.data_wr_i (wb_data),
		.rd_port   (rd_bus.read)
	);

	ctrl u_ctrl (
		.stall_i      (stall_i),
		.jmp_flag_i   (jmp_flag),
		.jmpb_rs1_i   (jmpb_rs1),
		.jmpb_rs2_i   (jmpb_rs2),
		.imm_i        (imm),
		.pc_id_i      (pc_id),
		.jmp_en_o     (jmp_en),
		.jmp_to_o     (jmp_to),
		.instr_mask_o (instr_mask),
		.hold_code_o  (hold_code)
	);

endmodule

`default_nettype wire

/* tests/core_assertions.sv */
////////////////////////////////////////
// concurrent checks on the core's memory
// port and hold behaviour, bound to core
////////////////////////////////////////
`default_nettype none

module core_assertions (
	input wire logic                clk,
	input wire logic                rst_i,
	input wire logic                stall_i,
	input wire logic                mem_state_o,
	input wire core_isa_pkg::word_t pc_o
);

	// no memory write may happen while the core is stalled
	no_write_in_stall: assert property (@(posedge clk) disable iff (rst_i)
		stall_i |-> mem_state_o == core_pipe_pkg::MEM_RD)
		else $error("memory write while stalled");

	// the PC must not move across a held edge
	pc_held: assert property (@(posedge clk) disable iff (rst_i)
		stall_i |=> $stable(pc_o))
		else $error("pc moved while held");

	read_after_reset: assert property (@(posedge clk)
		$fell(rst_i) |-> mem_state_o == core_pipe_pkg::MEM_RD)
		else $error("memory write right after reset");

endmodule

bind core core_assertions u_assertions (
	.clk         (clk),
	.rst_i       (rst_i),
	.stall_i     (stall_i),
	.mem_state_o (mem_state_o),
	.pc_o        (pc_o)
);

`default_nettype wire

/* tests/core_tb.sv */
////////////////////////////////////////
// directed testbench for core: clock,
// reset, memory models, watchdog, tests
////////////////////////////////////////
`default_nettype none

module core_tb;

	logic                clk = 1'b0;
	logic                rst_i;
	logic                stall_i;
	logic                stall_en;
	logic                mem_state_o;
	logic                instr_rd_en_o;
	core_isa_pkg::word_t instr_i, addr_instr_i, data_mem_i;
	core_isa_pkg::word_t data_mem_wr_o, addr_mem_o, pc_o;

	core_isa_pkg::word_t rom [256];
	core_isa_pkg::word_t ram [256];
	core_isa_pkg::word_t prog [$];
	core_isa_pkg::word_t rec_addr [$], rec_data [$], exp_addr [$], exp_data [$];
	int checks = 0;
	int errors = 0;
	int tests = 0;
	int failed_tests = 0;
	int budget = 0;

	core u_dut (.*);

	always #50 clk = ~clk;

	// memories answer in the same cycle
	assign instr_i      = rom[pc_o[9:2]];
	assign addr_instr_i = pc_o;
	assign data_mem_i   = ram[addr_mem_o[9:2]];

	always @(posedge clk) begin
		#10;
		stall_i = stall_en ? ($urandom % 4 == 0) : 1'b0;
	end

	// a store is recorded mid-cycle and lands in RAM before the next edge
	// the fetch read enable drops in every held cycle
	always @(negedge clk) begin
		if (!rst_i) begin
			check_bit("instr_rd_en_o", instr_rd_en_o, !stall_i);
			if (mem_state_o == core_pipe_pkg::MEM_WR) begin
				rec_addr.push_back(addr_mem_o);
				rec_data.push_back(data_mem_wr_o);
				ram[addr_mem_o[9:2]] = data_mem_wr_o;
				if (stall_i) begin
					$display("memory write seen at %0t while stall_i is high", $time);
					errors++;
				end
			end
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(negedge clk);
			cycles++;
			if (cycles > budget * 4 + 200) begin
				$display("timeout after %0d cycles, the program never reached its end", cycles);
				$display("tests failed");
				$finish;
			end
		end
	end

	function automatic core_isa_pkg::word_t r_type(logic [6:0] f7, core_isa_pkg::reg_addr_t rs2,
		core_isa_pkg::reg_addr_t rs1, logic [2:0] f3, core_isa_pkg::reg_addr_t rd);
		return {f7, rs2, rs1, f3, rd, core_isa_pkg::OPC_OP};
	endfunction

	function automatic core_isa_pkg::word_t i_type(core_isa_pkg::opcode_e opc,
		core_isa_pkg::reg_addr_t rd, core_isa_pkg::reg_addr_t rs1, logic [11:0] imm);
		return {imm, rs1, (opc == core_isa_pkg::OPC_LOAD) ? 3'b010 : 3'b000, rd, opc};
	endfunction

	function automatic core_isa_pkg::word_t s_type(core_isa_pkg::reg_addr_t rs2,
		core_isa_pkg::reg_addr_t rs1, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], core_isa_pkg::OPC_STORE};
	endfunction

	function automatic core_isa_pkg::word_t b_type(logic [2:0] f3, core_isa_pkg::reg_addr_t rs1,
		core_isa_pkg::reg_addr_t rs2, logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], core_isa_pkg::OPC_BRANCH};
	endfunction

	function automatic core_isa_pkg::word_t j_type(core_isa_pkg::reg_addr_t rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, core_isa_pkg::OPC_JAL};
	endfunction

	function automatic core_isa_pkg::word_t addi(core_isa_pkg::reg_addr_t rd,
		core_isa_pkg::reg_addr_t rs1, logic [11:0] imm);
		return i_type(core_isa_pkg::OPC_OP_IMM, rd, rs1, imm);
	endfunction

	function automatic core_isa_pkg::word_t ram_fill(int i);
		return 32'h5a00_0000 ^ (i * 32'h0001_0405) ^ (i << 2);
	endfunction

	task automatic expect_store(core_isa_pkg::word_t addr, core_isa_pkg::word_t data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic check_word(string name, core_isa_pkg::word_t got, core_isa_pkg::word_t exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(string name, int got, int exp);
		checks++;
		if (got != exp) begin
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_pc(core_isa_pkg::word_t exp);
		checks++;
		if (pc_o !== exp) begin
			$display("Mismatch at %0t: pc_o got %h expected %h", $time, pc_o, exp);
			errors++;
		end
	endtask

	// appends the self loop, loads memory, resets the core and runs to the end
	task automatic run_program(string name, logic with_stall);
		core_isa_pkg::word_t halt_pc;
		int settle;
		int err_before;
		err_before = errors;
		halt_pc = 32'(prog.size() * 4);
		prog.push_back(j_type(5'd0, 21'd0));
		budget += prog.size();
		for (int i = 0; i < 256; i++) begin
			rom[i] = (i < prog.size()) ? prog[i] : core_isa_pkg::NOP_INSTR;
			ram[i] = ram_fill(i);
		end
		@(posedge clk);
		#10;
		rst_i = 1'b1;
		repeat (5) @(posedge clk);
		stall_en = with_stall;
		#10;
		rst_i = 1'b0;
		rec_addr.delete();
		rec_data.delete();
		@(negedge clk);
		check_pc(core_isa_pkg::RESET_PC);
		do @(negedge clk); while (pc_o !== halt_pc);
		// two advancing edges take the self loop through its bubble and back to halt_pc
		settle = 0;
		while (settle < 2) begin
			if (!stall_i) begin
				settle++;
			end
			@(negedge clk);
		end
		stall_en = 1'b0;
		check_pc(halt_pc);
		check_count("store count", rec_addr.size(), exp_addr.size());
		for (int i = 0; i < rec_addr.size() && i < exp_addr.size(); i++) begin
			check_word("store address", rec_addr[i], exp_addr[i]);
			check_word("store data", rec_data[i], exp_data[i]);
		end
		tests++;
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: FAILED with %0d errors", name, errors - err_before);
		end
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic test_arith();
		core_isa_pkg::word_t v1, v2, v3, v4, v5, v6, v7;
		v1 = 5;
		v2 = v1 + 7;
		v3 = v2 + v1;
		v4 = v3 - v1;
		v5 = v4 & v2;
		v6 = v5 | v3;
		v7 = v6 ^ v1;
		prog = '{addi(1, 0, 5), addi(2, 1, 7), r_type(7'h00, 1, 2, 3'b000, 3),
			r_type(7'h20, 1, 3, 3'b000, 4), r_type(7'h00, 2, 4, 3'b111, 5),
			r_type(7'h00, 3, 5, 3'b110, 6), r_type(7'h00, 1, 6, 3'b100, 7),
			s_type(3, 0, 0), s_type(4, 0, 4), s_type(5, 0, 8), s_type(6, 0, 12),
			s_type(7, 0, 16)};
		expect_store(0, v3);
		expect_store(4, v4);
		expect_store(8, v5);
		expect_store(12, v6);
		expect_store(16, v7);
		run_program("arith", 1'b0);
	endtask

	task automatic test_load_store();
		prog = '{addi(1, 0, 12'h040), addi(2, 0, 12'hffd), s_type(2, 1, 4),
			i_type(core_isa_pkg::OPC_LOAD, 3, 1, 4), r_type(7'h00, 3, 3, 3'b000, 4),
			s_type(4, 1, 8), i_type(core_isa_pkg::OPC_LOAD, 5, 0, 12'h010),
			r_type(7'h00, 1, 5, 3'b100, 6), s_type(6, 1, 12)};
		expect_store(32'h44, -32'sd3);
		expect_store(32'h48, -32'sd6);
		expect_store(32'h4c, ram_fill(4) ^ 32'h40);
		run_program("load_store", 1'b0);
	endtask

	// both the plain and the stalled run use this program
	task automatic build_branch_program();
		prog = '{addi(1, 0, 3), addi(2, 0, 3), b_type(3'b000, 1, 2, 8), s_type(1, 0, 0),
			s_type(2, 0, 4), b_type(3'b001, 1, 2, 8), s_type(1, 0, 8), addi(3, 0, 9),
			b_type(3'b001, 1, 3, 8), s_type(3, 0, 12), b_type(3'b000, 1, 3, 8),
			s_type(3, 0, 16)};
		expect_store(4, 3);
		expect_store(8, 3);
		expect_store(16, 9);
	endtask

	task automatic test_jal();
		prog = '{addi(1, 0, 1), j_type(5, 12), s_type(1, 0, 0), s_type(1, 0, 4),
			s_type(5, 0, 8), s_type(1, 0, 12)};
		expect_store(8, 32'd4 + 32'd4);
		expect_store(12, 1);
		run_program("jal", 1'b0);
	endtask

	task automatic test_x0();
		prog = '{addi(0, 0, 55), addi(1, 0, 7), r_type(7'h00, 1, 1, 3'b000, 0),
			s_type(0, 0, 0), addi(3, 0, 0), s_type(3, 0, 4), s_type(0, 1, 1)};
		expect_store(0, 0);
		expect_store(4, 0);
		expect_store(8, 0);
		run_program("x0", 1'b0);
	endtask

	initial begin
		rst_i = 1'b1;
		stall_i = 1'b0;
		stall_en = 1'b0;
		void'($urandom(32'hbf61_8667));
		test_arith();
		test_load_store();
		build_branch_program();
		run_program("branch", 1'b0);
		test_jal();
		test_x0();
		build_branch_program();
		run_program("stall", 1'b1);
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* ecnu_core.f */
source/core_isa_pkg.sv
source/core_pipe_pkg.sv
source/core_bus_if.sv
source/fetch_stage.sv
source/id_stage.sv
source/ex_stage.sv
source/regs.sv
source/ctrl.sv
source/core.sv
tests/core_assertions.sv
tests/core_tb.sv

/* Makefile */
# Verilator build and run for ecnu_core

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= ecnu_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
